// ==== verif/boot.hex ====
// boot rom image, one 32-bit word per line in hex, word 0 first
0fc00093
00100113
00208193
fe010113
00112e23
00812c23
02010413
00000517
01050513
0005a283
00b50023
ffc5a303
80000237
00022023
0000006f
00000013

// ==== int_mem.f ====
hw/bus_pkg.sv
hw/mem_cfg_pkg.sv
hw/data_bus_split.sv
hw/ibus_merge.sv
hw/boot_ctrl.sv
hw/dual_port_sram.sv
hw/int_mem.sv
verif/int_mem_tb.sv

// ==== Makefile ====
TOP := int_mem_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): int_mem.f hw/*.sv verif/int_mem_tb.sv verif/boot.hex
	verilator --binary --timing -f int_mem.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing -f int_mem.f --top-module int_mem
	verilator --lint-only --timing -f int_mem.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== verif/int_mem_tb.sv ====
`timescale 1ns/1ns

module int_mem_tb
   import bus_pkg::*, mem_cfg_pkg::*;
();

   // about 600 accesses of at most two cycles plus waits and a wide margin
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int RAND_RUNS = 200;
   localparam logic [ADDR_W-1:0] REG_ADDR = ADDR_W'(1) << B_BIT;

   logic              clk_i;
   logic              rst_n_i;
   logic              boot_o;
   logic              cpu_reset_o;
   logic              i_avalid_i;
   logic [ADDR_W-1:0] i_addr_i;
   logic [DATA_W-1:0] i_rdata_o;
   logic              i_rvalid_o;
   logic              i_ready_o;
   logic              d_avalid_i;
   logic [ADDR_W-1:0] d_addr_i;
   logic [DATA_W-1:0] d_wdata_i;
   logic [STRB_W-1:0] d_wstrb_i;
   logic [DATA_W-1:0] d_rdata_o;
   logic              d_rvalid_o;
   logic              d_ready_o;

   // reference model state
   logic [DATA_W-1:0] boot_model [BOOT_WORDS];
   logic [DATA_W-1:0] model_mem [SRAM_WORDS];
   bit                word_known [SRAM_WORDS];
   logic              model_boot;

   // expected read data queued at acceptance
   logic [DATA_W-1:0] i_exp_q [$];
   logic [DATA_W-1:0] d_exp_q [$];
   logic [DATA_W-1:0] i_exp;
   logic [DATA_W-1:0] d_exp;

   int seed = 32'h754d_320e;
   int cycle_cnt = 0;
   int data_errors = 0;
   int instr_errors = 0;
   int ctrl_errors = 0;

   int_mem i_int_mem (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // expected word for a read on either port
   function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr,
                                                       input logic data_port);
      logic [ADDR_W-1:0] byte_addr;
      // the cpu only reads while out of reset so bit 1 reads 0
      if (data_port && addr[B_BIT]) begin
         return {30'b0, 1'b0, model_boot};
      end
      byte_addr = model_boot ? addr + ADDR_W'(BOOT_OFFSET) : addr;
      return model_mem[byte_addr[SRAM_ADDR_W-1:2]];
   endfunction

   task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              input logic [STRB_W-1:0] wstrb);
      logic [ADDR_W-1:0]      byte_addr;
      logic [SRAM_ADDR_W-3:0] widx;
      if (addr[B_BIT]) begin
         model_boot = wdata[0];
      end else begin
         byte_addr = model_boot ? addr + ADDR_W'(BOOT_OFFSET) : addr;
         widx = byte_addr[SRAM_ADDR_W-1:2];
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb[b]) begin
               model_mem[widx][b*8 +: 8] = wdata[b*8 +: 8];
            end
         end
         word_known[widx] = 1'b1;
      end
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("[FAIL] %0t ns %s expected %08h actual %08h", $time, name, expected, actual);
   endtask

   // one request on each enabled port held until accepted
   task automatic bus_step(
      input logic              i_en,
      input logic [ADDR_W-1:0] i_addr,
      input logic              d_en,
      input logic [ADDR_W-1:0] d_addr,
      input logic [DATA_W-1:0] d_wdata,
      input logic [STRB_W-1:0] d_wstrb
   );
      logic i_pend;
      logic d_pend;
      logic i_take;
      logic d_take;
      i_pend = i_en;
      d_pend = d_en;
      i_avalid_i = i_en;
      i_addr_i = i_addr;
      d_avalid_i = d_en;
      d_addr_i = d_addr;
      d_wdata_i = d_wdata;
      d_wstrb_i = d_wstrb;
      while (i_pend || d_pend) begin
         @(negedge clk_i);
         i_take = i_pend && i_ready_o;
         d_take = d_pend && d_ready_o;
         // reads see the memory as it was before this cycle's write
         if (i_take) begin
            i_exp_q.push_back(expected_read(i_addr, 1'b0));
         end
         if (d_take && !(|d_wstrb)) begin
            d_exp_q.push_back(expected_read(d_addr, 1'b1));
         end
         if (d_take && (|d_wstrb)) begin
            model_write(d_addr, d_wdata, d_wstrb);
         end
         i_pend = i_pend && !i_take;
         d_pend = d_pend && !d_take;
         @(posedge clk_i);
         #5;
         i_avalid_i = i_pend;
         d_avalid_i = d_pend;
      end
   endtask

   task automatic wait_responses();
      while (i_exp_q.size() != 0 || d_exp_q.size() != 0) begin
         @(posedge clk_i);
         #5;
      end
   endtask

   // compare read responses against the queued expectations
   always @(negedge clk_i) begin
      if (d_rvalid_o === 1'b1) begin
         if (d_exp_q.size() == 0) begin
            $display("data port returned a read response at %0t ns with none pending", $time);
            data_errors++;
         end else begin
            d_exp = d_exp_q.pop_front();
            if (d_rdata_o !== d_exp) begin
               report_mismatch("d_rdata_o", d_exp, d_rdata_o);
               data_errors++;
            end
         end
      end
      if (i_rvalid_o === 1'b1) begin
         if (i_exp_q.size() == 0) begin
            $display("instruction port returned a read response at %0t ns with none pending",
                     $time);
            instr_errors++;
         end else begin
            i_exp = i_exp_q.pop_front();
            if (i_rdata_o !== i_exp) begin
               report_mismatch("i_rdata_o", i_exp, i_rdata_o);
               instr_errors++;
            end
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      int unsigned            wait_cnt;
      logic [31:0]            rnd;
      logic [ADDR_W-1:0]      addr;
      logic [ADDR_W-1:0]      i_rd_addr;
      logic [DATA_W-1:0]      wdata;
      logic [STRB_W-1:0]      strb;
      logic [SRAM_ADDR_W-3:0] widx;

      rst_n_i = 1'b0;
      i_avalid_i = 1'b0;
      i_addr_i = '0;
      d_avalid_i = 1'b0;
      d_addr_i = '0;
      d_wdata_i = '0;
      d_wstrb_i = '0;

      // boot image as the copy should leave it at the top of the sram
      $readmemh(BOOT_HEXFILE, boot_model);
      model_boot = 1'b1;
      for (int k = 0; k < BOOT_WORDS; k++) begin
         widx = (SRAM_ADDR_W - 2)'(BOOT_OFFSET / 4 + k);
         model_mem[widx] = boot_model[k[BOOT_IDX_W-1:0]];
         word_known[widx] = 1'b1;
      end

      repeat (10) @(posedge clk_i);
      #5;
      if (boot_o !== 1'b1) begin
         report_mismatch("boot_o", 32'd1, 32'(boot_o));
         ctrl_errors++;
      end
      if (cpu_reset_o !== 1'b1) begin
         report_mismatch("cpu_reset_o", 32'd1, 32'(cpu_reset_o));
         ctrl_errors++;
      end
      rst_n_i = 1'b1;

      // copy deadline
      wait_cnt = 0;
      while (cpu_reset_o === 1'b1 && wait_cnt < BOOT_WORDS + 1) begin
         @(posedge clk_i);
         #5;
         wait_cnt++;
         // the copy writer holds the instruction port
         if (cpu_reset_o === 1'b1 && i_ready_o !== 1'b0) begin
            report_mismatch("i_ready_o", 32'd0, 32'(i_ready_o));
            ctrl_errors++;
         end
      end
      if (cpu_reset_o !== 1'b0) begin
         $display("cpu reset did not fall within %0d cycles of reset release", BOOT_WORDS + 1);
         ctrl_errors++;
      end

      // boot code through the remapped instruction port
      for (int k = 0; k < BOOT_WORDS; k++) begin
         bus_step(1'b1, 32'(k * 4), 1'b0, '0, '0, '0);
      end
      wait_responses();

      // word 0 is left alone so it still holds boot word 0 later
      for (int round = 0; round < 2; round++) begin
         for (int k = 1; k < BOOT_WORDS; k++) begin
            rnd = $random(seed);
            wdata = $random(seed);
            strb = rnd[3:0];
            if (strb == 4'b0000) begin
               strb = 4'b1000;
            end
            bus_step(1'b1, 32'((BOOT_WORDS - 1 - k) * 4), 1'b1, 32'(k * 4), wdata, strb);
         end
         for (int k = 0; k < BOOT_WORDS; k++) begin
            bus_step(1'b1, 32'(((k + 5) % BOOT_WORDS) * 4), 1'b1, 32'(k * 4), '0, '0);
         end
      end
      wait_responses();

      // boot register read then end of boot
      bus_step(1'b0, '0, 1'b1, REG_ADDR, '0, '0);
      wait_responses();
      bus_step(1'b0, '0, 1'b1, REG_ADDR, '0, '1);
      if (boot_o !== 1'b0) begin
         report_mismatch("boot_o", 32'd0, 32'(boot_o));
         ctrl_errors++;
      end
      for (int n = 0; n < CPU_RST_CYCLES; n++) begin
         if (cpu_reset_o !== 1'b1) begin
            report_mismatch("cpu_reset_o", 32'd1, 32'(cpu_reset_o));
            ctrl_errors++;
         end
         @(posedge clk_i);
         #5;
      end
      if (cpu_reset_o !== 1'b0) begin
         report_mismatch("cpu_reset_o", 32'd0, 32'(cpu_reset_o));
         ctrl_errors++;
      end

      // no remap any more
      bus_step(1'b1, 32'(BOOT_OFFSET), 1'b0, '0, '0, '0);
      for (int n = 0; n < RAND_RUNS; n++) begin
         rnd = $random(seed);
         wdata = $random(seed);
         addr = {20'b0, rnd[9:0], 2'b00};
         strb = rnd[13:10];
         // fresh words get every byte written
         if (!word_known[rnd[9:0]] || strb == 4'b0000) begin
            strb = 4'b1111;
         end
         i_rd_addr = 32'(BOOT_OFFSET) + {26'b0, rnd[17:14], 2'b00};
         bus_step(1'b1, i_rd_addr, 1'b1, addr, wdata, strb);
         bus_step(1'b0, '0, 1'b1, addr, '0, '0);
      end
      wait_responses();
      repeat (4) @(posedge clk_i);

      $display("errors: data %0d, instruction %0d, control %0d",
               data_errors, instr_errors, ctrl_errors);
      if (data_errors + instr_errors + ctrl_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== hw/int_mem.sv ====
`timescale 1ns/1ns

module int_mem
   import bus_pkg::*, mem_cfg_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,

   output logic              boot_o,
   output logic              cpu_reset_o,

   // cpu instruction bus, read only
   input  logic              i_avalid_i,
   input  logic [ADDR_W-1:0] i_addr_i,
   output logic [DATA_W-1:0] i_rdata_o,
   output logic              i_rvalid_o,
   output logic              i_ready_o,

   // cpu data bus
   input  logic              d_avalid_i,
   input  logic [ADDR_W-1:0] d_addr_i,
   input  logic [DATA_W-1:0] d_wdata_i,
   input  logic [STRB_W-1:0] d_wstrb_i,
   output logic [DATA_W-1:0] d_rdata_o,
   output logic              d_rvalid_o,
   output logic              d_ready_o
);

   logic [ADDR_W-1:0] i_addr_map;
   logic [ADDR_W-1:0] d_addr_map;

   // split outputs
   logic              mem_avalid;
   logic [DATA_W-1:0] mem_rdata;
   logic              mem_rvalid;
   logic              mem_ready;
   logic              reg_avalid;
   logic [DATA_W-1:0] reg_rdata;
   logic              reg_rvalid;
   logic              reg_ready;

   // boot copy writer
   logic              bw_avalid;
   logic [ADDR_W-1:0] bw_addr;
   logic [DATA_W-1:0] bw_wdata;
   logic [STRB_W-1:0] bw_wstrb;
   logic              bw_ready;

   // merged sram instruction port
   logic              s_avalid;
   logic [ADDR_W-1:0] s_addr;
   logic [DATA_W-1:0] s_wdata;
   logic [STRB_W-1:0] s_wstrb;
   logic [DATA_W-1:0] s_rdata;
   logic              s_rvalid;
   logic              s_ready;

   // boot code runs from the top of the sram while the flag is set
   assign i_addr_map = boot_o ? i_addr_i + ADDR_W'(BOOT_OFFSET) : i_addr_i;
   assign d_addr_map = boot_o ? d_addr_i + ADDR_W'(BOOT_OFFSET) : d_addr_i;

   data_bus_split data_split0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .m_avalid_i(d_avalid_i), .m_addr_i(d_addr_i), .m_wdata_i(d_wdata_i),
      .m_wstrb_i(d_wstrb_i), .m_rdata_o(d_rdata_o), .m_rvalid_o(d_rvalid_o),
      .m_ready_o(d_ready_o),
      .mem_avalid_o(mem_avalid), .mem_rdata_i(mem_rdata), .mem_rvalid_i(mem_rvalid),
      .mem_ready_i(mem_ready),
      .reg_avalid_o(reg_avalid), .reg_rdata_i(reg_rdata), .reg_rvalid_i(reg_rvalid),
      .reg_ready_i(reg_ready)
   );

   boot_ctrl boot_ctrl0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .reg_avalid_i(reg_avalid), .reg_wdata_i(d_wdata_i[1:0]), .reg_wstrb_i(d_wstrb_i),
      .reg_rdata_o(reg_rdata), .reg_rvalid_o(reg_rvalid), .reg_ready_o(reg_ready),
      .boot_o(boot_o), .cpu_reset_o(cpu_reset_o),
      .sram_avalid_o(bw_avalid), .sram_addr_o(bw_addr), .sram_wdata_o(bw_wdata),
      .sram_wstrb_o(bw_wstrb), .sram_ready_i(bw_ready)
   );

   ibus_merge ibus_merge0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .w_avalid_i(bw_avalid), .w_addr_i(bw_addr), .w_wdata_i(bw_wdata),
      .w_wstrb_i(bw_wstrb), .w_ready_o(bw_ready),
      .r_avalid_i(i_avalid_i), .r_addr_i(i_addr_map), .r_ready_o(i_ready_o),
      .r_rdata_o(i_rdata_o), .r_rvalid_o(i_rvalid_o),
      .s_avalid_o(s_avalid), .s_addr_o(s_addr), .s_wdata_o(s_wdata), .s_wstrb_o(s_wstrb),
      .s_rdata_i(s_rdata), .s_rvalid_i(s_rvalid), .s_ready_i(s_ready)
   );

   dual_port_sram int_sram (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .i_avalid_i(s_avalid), .i_addr_i(s_addr[SRAM_ADDR_W-1:2]), .i_wdata_i(s_wdata),
      .i_wstrb_i(s_wstrb), .i_rdata_o(s_rdata), .i_rvalid_o(s_rvalid), .i_ready_o(s_ready),
      .d_avalid_i(mem_avalid), .d_addr_i(d_addr_map[SRAM_ADDR_W-1:2]),
      .d_wdata_i(d_wdata_i), .d_wstrb_i(d_wstrb_i), .d_rdata_o(mem_rdata),
      .d_rvalid_o(mem_rvalid), .d_ready_o(mem_ready)
   );

endmodule

// ==== hw/dual_port_sram.sv ====
`timescale 1ns/1ns

module dual_port_sram
   import bus_pkg::*, mem_cfg_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   // instruction port
   input  logic                   i_avalid_i,
   input  logic [SRAM_ADDR_W-3:0] i_addr_i,
   input  logic [DATA_W-1:0]      i_wdata_i,
   input  logic [STRB_W-1:0]      i_wstrb_i,
   output logic [DATA_W-1:0]      i_rdata_o,
   output logic                   i_rvalid_o,
   output logic                   i_ready_o,

   // data port
   input  logic                   d_avalid_i,
   input  logic [SRAM_ADDR_W-3:0] d_addr_i,
   input  logic [DATA_W-1:0]      d_wdata_i,
   input  logic [STRB_W-1:0]      d_wstrb_i,
   output logic [DATA_W-1:0]      d_rdata_o,
   output logic                   d_rvalid_o,
   output logic                   d_ready_o
);

   logic [DATA_W-1:0] mem [SRAM_WORDS];

   // byte writes, data port comes last so it wins on a clash
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < STRB_W; b++) begin
         if (i_avalid_i && i_wstrb_i[b]) begin
            mem[i_addr_i][b*8 +: 8] <= i_wdata_i[b*8 +: 8];
         end
      end
      for (int b = 0; b < STRB_W; b++) begin
         if (d_avalid_i && d_wstrb_i[b]) begin
            mem[d_addr_i][b*8 +: 8] <= d_wdata_i[b*8 +: 8];
         end
      end
      if (i_avalid_i && !(|i_wstrb_i)) begin
         i_rdata_o <= mem[i_addr_i];
      end
      if (d_avalid_i && !(|d_wstrb_i)) begin
         d_rdata_o <= mem[d_addr_i];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         i_rvalid_o <= 1'b0;
         d_rvalid_o <= 1'b0;
      end else begin
         i_rvalid_o <= i_avalid_i && !(|i_wstrb_i);
         d_rvalid_o <= d_avalid_i && !(|d_wstrb_i);
      end
   end

   assign i_ready_o = 1'b1;
   assign d_ready_o = 1'b1;

endmodule

// ==== hw/boot_ctrl.sv ====
`timescale 1ns/1ns

module boot_ctrl
   import bus_pkg::*, mem_cfg_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,

   // boot register, single address
   input  logic              reg_avalid_i,
   input  logic [1:0]        reg_wdata_i,
   input  logic [STRB_W-1:0] reg_wstrb_i,
   output logic [DATA_W-1:0] reg_rdata_o,
   output logic              reg_rvalid_o,
   output logic              reg_ready_o,

   output logic              boot_o,
   output logic              cpu_reset_o,

   // copy writer towards the sram
   output logic              sram_avalid_o,
   output logic [ADDR_W-1:0] sram_addr_o,
   output logic [DATA_W-1:0] sram_wdata_o,
   output logic [STRB_W-1:0] sram_wstrb_o,
   input  logic              sram_ready_i
);

   logic [DATA_W-1:0]        rom [BOOT_WORDS];
   logic [BOOT_IDX_W:0]      rd_cnt;
   logic [BOOT_IDX_W-1:0]    wr_idx;
   logic [DATA_W-1:0]        rom_q;
   logic                     wr_vld;
   logic                     copy_adv;
   logic                     copy_busy;
   logic                     boot_q;
   logic [CPU_RST_CNT_W-1:0] rst_cnt;
   logic                     reg_wr;
   logic                     reg_rd;

   initial begin
      $readmemh(BOOT_HEXFILE, rom);
   end

   // pipeline moves when no write is pending or the pending one is taken
   assign copy_adv  = !wr_vld || sram_ready_i;
   assign copy_busy = wr_vld || (rd_cnt < (BOOT_IDX_W + 1)'(BOOT_WORDS));

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_cnt <= '0;
         wr_vld <= 1'b0;
      end else if (copy_adv) begin
         if (rd_cnt < (BOOT_IDX_W + 1)'(BOOT_WORDS)) begin
            rd_cnt <= rd_cnt + 1'b1;
            wr_vld <= 1'b1;
         end else begin
            wr_vld <= 1'b0;
         end
      end
   end

   // registered rom read, one cycle ahead of the write
   always_ff @(posedge clk_i) begin
      if (copy_adv) begin
         rom_q  <= rom[rd_cnt[BOOT_IDX_W-1:0]];
         wr_idx <= rd_cnt[BOOT_IDX_W-1:0];
      end
   end

   assign sram_avalid_o = wr_vld;
   assign sram_addr_o   = ADDR_W'(BOOT_OFFSET) + ADDR_W'({wr_idx, 2'b00});
   assign sram_wdata_o  = rom_q;
   assign sram_wstrb_o  = '1;

   assign reg_ready_o = 1'b1;
   assign reg_wr      = reg_avalid_i && (|reg_wstrb_i);
   assign reg_rd      = reg_avalid_i && !(|reg_wstrb_i);

   // boot flag and cpu reset pulse
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         boot_q       <= 1'b1;
         rst_cnt      <= '0;
         reg_rvalid_o <= 1'b0;
      end else begin
         reg_rvalid_o <= reg_rd;
         if (reg_wr) begin
            boot_q <= reg_wdata_i[0];
         end
         // bit 1 forces a pulse, a flag change always gives one
         if (reg_wr && (reg_wdata_i[1] || (reg_wdata_i[0] != boot_q))) begin
            rst_cnt <= CPU_RST_CNT_W'(CPU_RST_CYCLES);
         end else if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reg_rd) begin
         reg_rdata_o <= DATA_W'({cpu_reset_o, boot_q});
      end
   end

   assign boot_o      = boot_q;
   assign cpu_reset_o = copy_busy || (rst_cnt != '0);

endmodule

// ==== hw/ibus_merge.sv ====
`timescale 1ns/1ns

module ibus_merge
   import bus_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,

   // boot copy writer, highest priority
   input  logic              w_avalid_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_wdata_i,
   input  logic [STRB_W-1:0] w_wstrb_i,
   output logic              w_ready_o,

   // cpu instruction reader
   input  logic              r_avalid_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic              r_ready_o,
   output logic [DATA_W-1:0] r_rdata_o,
   output logic              r_rvalid_o,

   // sram instruction port
   output logic              s_avalid_o,
   output logic [ADDR_W-1:0] s_addr_o,
   output logic [DATA_W-1:0] s_wdata_o,
   output logic [STRB_W-1:0] s_wstrb_o,
   input  logic [DATA_W-1:0] s_rdata_i,
   input  logic              s_rvalid_i,
   input  logic              s_ready_i
);

   logic grant_w;
   logic r_rd_q;

   // writer owns the port whenever it asks
   assign grant_w = w_avalid_i;

   assign s_avalid_o = w_avalid_i || r_avalid_i;
   assign s_addr_o   = grant_w ? w_addr_i : r_addr_i;
   assign s_wdata_o  = grant_w ? w_wdata_i : '0;

   // reader only ever reads
   assign s_wstrb_o  = grant_w ? w_wstrb_i : '0;

   assign w_ready_o = s_ready_i;
   assign r_ready_o = s_ready_i && !grant_w;

   // response goes back to the reader one cycle after its accept
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         r_rd_q <= 1'b0;
      end else begin
         r_rd_q <= r_avalid_i && r_ready_o;
      end
   end

   assign r_rdata_o  = s_rdata_i;
   assign r_rvalid_o = s_rvalid_i && r_rd_q;

endmodule

// ==== hw/data_bus_split.sv ====
`timescale 1ns/1ns

module data_bus_split
   import bus_pkg::*, mem_cfg_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,

   // cpu data bus
   input  logic              m_avalid_i,
   input  logic [ADDR_W-1:0] m_addr_i,
   input  logic [DATA_W-1:0] m_wdata_i,
   input  logic [STRB_W-1:0] m_wstrb_i,
   output logic [DATA_W-1:0] m_rdata_o,
   output logic              m_rvalid_o,
   output logic              m_ready_o,

   // sram data port
   output logic              mem_avalid_o,
   input  logic [DATA_W-1:0] mem_rdata_i,
   input  logic              mem_rvalid_i,
   input  logic              mem_ready_i,

   // boot register
   output logic              reg_avalid_o,
   input  logic [DATA_W-1:0] reg_rdata_i,
   input  logic              reg_rvalid_i,
   input  logic              reg_ready_i
);

   logic sel_reg;
   logic rd_sel_q;

   // wdata fans out in the top level, only address and strobe steer here
   assign sel_reg = m_addr_i[B_BIT];

   assign mem_avalid_o = m_avalid_i && !sel_reg;
   assign reg_avalid_o = m_avalid_i && sel_reg;
   assign m_ready_o    = sel_reg ? reg_ready_i : mem_ready_i;

   // remember where the last accepted read went
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_sel_q <= 1'b0;
      end else if (m_avalid_i && m_ready_o && !(|m_wstrb_i)) begin
         rd_sel_q <= sel_reg;
      end
   end

   assign m_rdata_o  = rd_sel_q ? reg_rdata_i : mem_rdata_i;
   assign m_rvalid_o = rd_sel_q ? reg_rvalid_i : mem_rvalid_i;

endmodule

// ==== hw/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

   // sram byte address width, 1024 words
   localparam int unsigned SRAM_ADDR_W = 12;
   localparam int unsigned SRAM_WORDS = 2 ** (SRAM_ADDR_W - 2);

   // boot rom byte address width, 16 words
   localparam int unsigned BOOTROM_ADDR_W = 6;
   localparam int unsigned BOOT_WORDS = 2 ** (BOOTROM_ADDR_W - 2);
   localparam int unsigned BOOT_IDX_W = BOOTROM_ADDR_W - 2;

   // data address bit that selects the boot register
   localparam int unsigned B_BIT = 31;

   // boot image sits at the very top of the sram
   localparam int unsigned BOOT_OFFSET = (2 ** SRAM_ADDR_W) - (2 ** BOOTROM_ADDR_W);

   // cpu reset pulse when boot ends
   localparam int unsigned CPU_RST_CYCLES = 8;
   localparam int unsigned CPU_RST_CNT_W = $clog2(CPU_RST_CYCLES + 1);

   // boot image, one hex word per line
   localparam BOOT_HEXFILE = "verif/boot.hex";

endpackage

// ==== hw/bus_pkg.sv ====
package bus_pkg;

   // cpu bus field widths

   // byte address
   localparam int unsigned ADDR_W = 32;

   // read and write data
   localparam int unsigned DATA_W = 32;

   // one strobe per data byte
   localparam int unsigned STRB_W = DATA_W / 8;

   // a zero strobe is a read, anything else a write
   // the handshake is valid/ready on the request side and
   // rvalid one cycle after an accepted read

endpackage
